// ==== rv_monitor_pkg.sv ====
`default_nettype none

package rv_monitor_pkg;

    localparam int unsigned XLEN       = 32; // data and pc width
    localparam int unsigned REG_ADDR_W = 5;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        OPC_LUI      = 7'b0110111,
        OPC_AUIPC    = 7'b0010111,
        OPC_JAL      = 7'b1101111,
        OPC_JALR     = 7'b1100111,
        OPC_BRANCH   = 7'b1100011,
        OPC_LOAD     = 7'b0000011,
        OPC_STORE    = 7'b0100011,
        OPC_OP_IMM   = 7'b0010011,
        OPC_OP       = 7'b0110011,
        OPC_MISC_MEM = 7'b0001111, // FENCE
        OPC_SYSTEM   = 7'b1110011  // ECALL, EBREAK
    } opcode_e;

    // branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // load funct3
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    // store funct3
    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;

    // alu funct3 needed for legality and the checked group
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SR      = 3'b101; // SRL/SRA, SRLI/SRAI
    localparam logic [2:0] F3_XORI    = 3'b100;
    localparam logic [2:0] F3_JALR    = 3'b000;
    localparam logic [2:0] F3_FENCE   = 3'b000;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB, SRA, SRAI

    typedef enum logic [2:0] {
        KIND_XORI    = 3'd0,
        KIND_AUIPC   = 3'd1,
        KIND_JAL     = 3'd2,
        KIND_BLT     = 3'd3,
        KIND_OTHER   = 3'd4, // legal but not value checked
        KIND_ILLEGAL = 3'd5
    } inst_kind_e;

    // failure mask layout
    localparam int unsigned FAIL_W     = 4;
    localparam int unsigned FAIL_VALUE = 0;
    localparam int unsigned FAIL_DST   = 1;
    localparam int unsigned FAIL_WE    = 2;
    localparam int unsigned FAIL_PC    = 3;

endpackage

`default_nettype wire

// ==== rv_inst_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_inst_decoder (
    input  logic [rv_monitor_pkg::XLEN-1:0]       inst_i,
    output rv_monitor_pkg::inst_kind_e            kind_o,
    output logic [rv_monitor_pkg::REG_ADDR_W-1:0] rd_o,
    output logic [rv_monitor_pkg::XLEN-1:0]       imm_i_o,
    output logic [rv_monitor_pkg::XLEN-1:0]       imm_b_o,
    output logic [rv_monitor_pkg::XLEN-1:0]       imm_j_o,
    output logic [rv_monitor_pkg::XLEN-1:0]       imm_u_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       legal;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign rd_o   = inst_i[11:7];

    // all immediates sign extended from bit 31
    assign imm_i_o = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_b_o = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j_o = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
    assign imm_u_o = {inst_i[31:12], 12'b0};

    always_comb begin
        case (opcode)
            rv_monitor_pkg::OPC_LUI,
            rv_monitor_pkg::OPC_AUIPC:  legal = 1'b1;
            rv_monitor_pkg::OPC_JAL:    legal = !inst_i[21]; // offset bit 1 must be clear
            rv_monitor_pkg::OPC_JALR:
                legal = (funct3 == rv_monitor_pkg::F3_JALR) && (inst_i[21:20] == 2'b00);
            rv_monitor_pkg::OPC_BRANCH:
                legal = (funct3 inside {rv_monitor_pkg::F3_BEQ, rv_monitor_pkg::F3_BNE,
                                        rv_monitor_pkg::F3_BLT, rv_monitor_pkg::F3_BGE,
                                        rv_monitor_pkg::F3_BLTU, rv_monitor_pkg::F3_BGEU})
                        && !inst_i[8];
            rv_monitor_pkg::OPC_LOAD:
                legal = funct3 inside {rv_monitor_pkg::F3_LB, rv_monitor_pkg::F3_LH,
                                       rv_monitor_pkg::F3_LW, rv_monitor_pkg::F3_LBU,
                                       rv_monitor_pkg::F3_LHU};
            rv_monitor_pkg::OPC_STORE:
                legal = funct3 inside {rv_monitor_pkg::F3_SB, rv_monitor_pkg::F3_SH,
                                       rv_monitor_pkg::F3_SW};
            rv_monitor_pkg::OPC_OP_IMM: begin
                // only the shift forms constrain the upper bits
                if (funct3 == rv_monitor_pkg::F3_SLL)
                    legal = (funct7 == rv_monitor_pkg::F7_BASE);
                else if (funct3 == rv_monitor_pkg::F3_SR)
                    legal = funct7 inside {rv_monitor_pkg::F7_BASE, rv_monitor_pkg::F7_ALT};
                else
                    legal = 1'b1;
            end
            rv_monitor_pkg::OPC_OP:
                legal = (funct7 == rv_monitor_pkg::F7_BASE) ||
                        ((funct7 == rv_monitor_pkg::F7_ALT) &&
                         (funct3 inside {rv_monitor_pkg::F3_ADD_SUB, rv_monitor_pkg::F3_SR}));
            rv_monitor_pkg::OPC_MISC_MEM:
                legal = (funct3 == rv_monitor_pkg::F3_FENCE) && (inst_i[19:15] == 5'd0) &&
                        (inst_i[11:7] == 5'd0);
            rv_monitor_pkg::OPC_SYSTEM: // bit 20 picks ECALL or EBREAK
                legal = (inst_i[31:21] == 11'd0) && (inst_i[19:7] == 13'd0);
            default:                    legal = 1'b0;
        endcase
    end

    always_comb begin
        if (!legal)
            kind_o = rv_monitor_pkg::KIND_ILLEGAL;
        else if (opcode == rv_monitor_pkg::OPC_OP_IMM && funct3 == rv_monitor_pkg::F3_XORI)
            kind_o = rv_monitor_pkg::KIND_XORI;
        else if (opcode == rv_monitor_pkg::OPC_AUIPC)
            kind_o = rv_monitor_pkg::KIND_AUIPC;
        else if (opcode == rv_monitor_pkg::OPC_JAL)
            kind_o = rv_monitor_pkg::KIND_JAL;
        else if (opcode == rv_monitor_pkg::OPC_BRANCH && funct3 == rv_monitor_pkg::F3_BLT)
            kind_o = rv_monitor_pkg::KIND_BLT;
        else
            kind_o = rv_monitor_pkg::KIND_OTHER;
    end

endmodule

`default_nettype wire

// ==== rv_golden_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_golden_alu (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  valid_i,
    input  rv_monitor_pkg::inst_kind_e            kind_i,
    input  logic [rv_monitor_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic [rv_monitor_pkg::XLEN-1:0]       imm_i_i,
    input  logic [rv_monitor_pkg::XLEN-1:0]       imm_b_i,
    input  logic [rv_monitor_pkg::XLEN-1:0]       imm_j_i,
    input  logic [rv_monitor_pkg::XLEN-1:0]       imm_u_i,
    input  logic [rv_monitor_pkg::XLEN-1:0]       pc_i,
    input  logic [rv_monitor_pkg::XLEN-1:0]       rs1_i,
    input  logic [rv_monitor_pkg::XLEN-1:0]       rs2_i,
    input  logic [rv_monitor_pkg::XLEN-1:0]       wb_val_i,
    input  logic [rv_monitor_pkg::REG_ADDR_W-1:0] wb_dst_i,
    input  logic                                  wb_we_i,
    output logic                                  s1_valid_o,
    output rv_monitor_pkg::inst_kind_e            s1_kind_o,
    output logic [rv_monitor_pkg::XLEN-1:0]       s1_pc_o,
    output logic [rv_monitor_pkg::XLEN-1:0]       s1_next_pc_o,
    output logic [rv_monitor_pkg::XLEN-1:0]       s1_exp_val_o,
    output logic [rv_monitor_pkg::REG_ADDR_W-1:0] s1_exp_dst_o,
    output logic                                  s1_exp_we_o,
    output logic [rv_monitor_pkg::XLEN-1:0]       s1_obs_val_o,
    output logic [rv_monitor_pkg::REG_ADDR_W-1:0] s1_obs_dst_o,
    output logic                                  s1_obs_we_o
);

    logic [rv_monitor_pkg::XLEN-1:0] pc_plus4;
    logic [rv_monitor_pkg::XLEN-1:0] exp_val;
    logic [rv_monitor_pkg::XLEN-1:0] next_pc;
    logic                            exp_we;
    logic                            blt_taken;

    assign pc_plus4  = pc_i + 32'd4;
    assign blt_taken = $signed(rs1_i) < $signed(rs2_i);

    always_comb begin
        exp_val = pc_plus4; // link value of JAL
        exp_we  = 1'b0;
        next_pc = pc_plus4;
        case (kind_i)
            rv_monitor_pkg::KIND_XORI: begin
                exp_val = rs1_i ^ imm_i_i; // sign-extended immediate per the ISA
                exp_we  = (rd_i != '0);
            end
            rv_monitor_pkg::KIND_AUIPC: begin
                exp_val = pc_i + imm_u_i;
                exp_we  = (rd_i != '0);
            end
            rv_monitor_pkg::KIND_JAL: begin
                exp_we  = (rd_i != '0);
                next_pc = pc_i + imm_j_i;
            end
            rv_monitor_pkg::KIND_BLT: next_pc = blt_taken ? (pc_i + imm_b_i) : pc_plus4;
            default: ; // no write expected and sequential flow
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid_o <= 1'b0;
        end else begin
            s1_valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            s1_kind_o    <= kind_i;
            s1_pc_o      <= pc_i;
            s1_next_pc_o <= next_pc;
            s1_exp_val_o <= exp_val;
            s1_exp_dst_o <= rd_i;
            s1_exp_we_o  <= exp_we;
            s1_obs_val_o <= wb_val_i; // what the core actually retired
            s1_obs_dst_o <= wb_dst_i;
            s1_obs_we_o  <= wb_we_i;
        end
    end

endmodule

`default_nettype wire

// ==== rv_flow_tracker.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_flow_tracker (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            s1_valid_i,
    input  logic [rv_monitor_pkg::XLEN-1:0] s1_pc_i,
    input  logic [rv_monitor_pkg::XLEN-1:0] s1_next_pc_i,
    output logic                            pc_mismatch_o
);

    logic                            exp_valid_q; // set once any record has retired
    logic [rv_monitor_pkg::XLEN-1:0] exp_pc_q;

    // compare against the pc promised by the previous retirement
    assign pc_mismatch_o = s1_valid_i && exp_valid_q && (s1_pc_i != exp_pc_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            exp_valid_q <= 1'b0;
        end else if (s1_valid_i) begin
            exp_valid_q <= 1'b1;
        end
    end

    // idle cycles keep the expectation untouched
    always_ff @(posedge clk) begin
        if (s1_valid_i) begin
            exp_pc_q <= s1_next_pc_i;
        end
    end

endmodule

`default_nettype wire

// ==== rv_result_compare.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_result_compare (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  s1_valid_i,
    input  rv_monitor_pkg::inst_kind_e            s1_kind_i,
    input  logic [rv_monitor_pkg::XLEN-1:0]       s1_exp_val_i,
    input  logic [rv_monitor_pkg::REG_ADDR_W-1:0] s1_exp_dst_i,
    input  logic                                  s1_exp_we_i,
    input  logic [rv_monitor_pkg::XLEN-1:0]       s1_obs_val_i,
    input  logic [rv_monitor_pkg::REG_ADDR_W-1:0] s1_obs_dst_i,
    input  logic                                  s1_obs_we_i,
    input  logic                                  pc_mismatch_i,
    output logic                                  chk_valid_o,
    output logic [rv_monitor_pkg::FAIL_W-1:0]     chk_fail_o,
    output logic                                  chk_illegal_o
);

    logic                              value_checked;
    logic                              we_checked;
    logic [rv_monitor_pkg::FAIL_W-1:0] fail_mask;

    // value and destination only for the computed group
    assign value_checked = s1_kind_i inside {rv_monitor_pkg::KIND_XORI,
                                             rv_monitor_pkg::KIND_AUIPC,
                                             rv_monitor_pkg::KIND_JAL};
    assign we_checked    = (s1_kind_i != rv_monitor_pkg::KIND_OTHER);

    always_comb begin
        fail_mask = '0;
        fail_mask[rv_monitor_pkg::FAIL_VALUE] = value_checked && (s1_obs_val_i != s1_exp_val_i);
        fail_mask[rv_monitor_pkg::FAIL_DST]   = value_checked && (s1_obs_dst_i != s1_exp_dst_i);
        fail_mask[rv_monitor_pkg::FAIL_WE]    = we_checked && (s1_obs_we_i != s1_exp_we_i);
        fail_mask[rv_monitor_pkg::FAIL_PC]    = pc_mismatch_i;
    end

    // flags are only non-zero alongside a valid output
    always_ff @(posedge clk) begin
        if (rst) begin
            chk_valid_o   <= 1'b0;
            chk_fail_o    <= '0;
            chk_illegal_o <= 1'b0;
        end else begin
            chk_valid_o   <= s1_valid_i;
            chk_fail_o    <= s1_valid_i ? fail_mask : '0;
            chk_illegal_o <= s1_valid_i && (s1_kind_i == rv_monitor_pkg::KIND_ILLEGAL);
        end
    end

endmodule

`default_nettype wire

// ==== rv_retire_monitor.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_retire_monitor (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  retire_valid_i,
    input  logic [rv_monitor_pkg::XLEN-1:0]       retire_pc_i,
    input  logic [rv_monitor_pkg::XLEN-1:0]       retire_inst_i,
    input  logic [rv_monitor_pkg::XLEN-1:0]       retire_rs1_i,
    input  logic [rv_monitor_pkg::XLEN-1:0]       retire_rs2_i,
    input  logic [rv_monitor_pkg::XLEN-1:0]       retire_wb_val_i,
    input  logic [rv_monitor_pkg::REG_ADDR_W-1:0] retire_wb_dst_i,
    input  logic                                  retire_wb_we_i,
    output logic                                  chk_valid_o,
    output logic [rv_monitor_pkg::FAIL_W-1:0]     chk_fail_o,
    output logic                                  chk_illegal_o
);

    rv_monitor_pkg::inst_kind_e            dec_kind;
    logic [rv_monitor_pkg::REG_ADDR_W-1:0] dec_rd;
    logic [rv_monitor_pkg::XLEN-1:0]       dec_imm_i;
    logic [rv_monitor_pkg::XLEN-1:0]       dec_imm_b;
    logic [rv_monitor_pkg::XLEN-1:0]       dec_imm_j;
    logic [rv_monitor_pkg::XLEN-1:0]       dec_imm_u;

    logic                                  s1_valid;
    rv_monitor_pkg::inst_kind_e            s1_kind;
    logic [rv_monitor_pkg::XLEN-1:0]       s1_pc;
    logic [rv_monitor_pkg::XLEN-1:0]       s1_next_pc;
    logic [rv_monitor_pkg::XLEN-1:0]       s1_exp_val;
    logic [rv_monitor_pkg::REG_ADDR_W-1:0] s1_exp_dst;
    logic                                  s1_exp_we;
    logic [rv_monitor_pkg::XLEN-1:0]       s1_obs_val;
    logic [rv_monitor_pkg::REG_ADDR_W-1:0] s1_obs_dst;
    logic                                  s1_obs_we;
    logic                                  pc_mismatch;

    rv_inst_decoder u_decoder (
        .inst_i  (retire_inst_i),
        .kind_o  (dec_kind),
        .rd_o    (dec_rd),
        .imm_i_o (dec_imm_i),
        .imm_b_o (dec_imm_b),
        .imm_j_o (dec_imm_j),
        .imm_u_o (dec_imm_u)
    );

    // stage 1 holds golden results next to the observed ones
    rv_golden_alu u_golden (
        .clk          (clk),
        .rst          (rst),
        .valid_i      (retire_valid_i),
        .kind_i       (dec_kind),
        .rd_i         (dec_rd),
        .imm_i_i      (dec_imm_i),
        .imm_b_i      (dec_imm_b),
        .imm_j_i      (dec_imm_j),
        .imm_u_i      (dec_imm_u),
        .pc_i         (retire_pc_i),
        .rs1_i        (retire_rs1_i),
        .rs2_i        (retire_rs2_i),
        .wb_val_i     (retire_wb_val_i),
        .wb_dst_i     (retire_wb_dst_i),
        .wb_we_i      (retire_wb_we_i),
        .s1_valid_o   (s1_valid),
        .s1_kind_o    (s1_kind),
        .s1_pc_o      (s1_pc),
        .s1_next_pc_o (s1_next_pc),
        .s1_exp_val_o (s1_exp_val),
        .s1_exp_dst_o (s1_exp_dst),
        .s1_exp_we_o  (s1_exp_we),
        .s1_obs_val_o (s1_obs_val),
        .s1_obs_dst_o (s1_obs_dst),
        .s1_obs_we_o  (s1_obs_we)
    );

    rv_flow_tracker u_flow (
        .clk           (clk),
        .rst           (rst),
        .s1_valid_i    (s1_valid),
        .s1_pc_i       (s1_pc),
        .s1_next_pc_i  (s1_next_pc),
        .pc_mismatch_o (pc_mismatch)
    );

    // stage 2 registers the report
    rv_result_compare u_compare (
        .clk           (clk),
        .rst           (rst),
        .s1_valid_i    (s1_valid),
        .s1_kind_i     (s1_kind),
        .s1_exp_val_i  (s1_exp_val),
        .s1_exp_dst_i  (s1_exp_dst),
        .s1_exp_we_i   (s1_exp_we),
        .s1_obs_val_i  (s1_obs_val),
        .s1_obs_dst_i  (s1_obs_dst),
        .s1_obs_we_i   (s1_obs_we),
        .pc_mismatch_i (pc_mismatch),
        .chk_valid_o   (chk_valid_o),
        .chk_fail_o    (chk_fail_o),
        .chk_illegal_o (chk_illegal_o)
    );

endmodule

`default_nettype wire

// ==== rv_retire_monitor_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_retire_monitor_chk (
    input logic                              clk,
    input logic                              rst,
    input logic                              retire_valid_i,
    input logic                              chk_valid_i,
    input logic [rv_monitor_pkg::FAIL_W-1:0] chk_fail_i,
    input logic                              chk_illegal_i
);

    int unsigned fail_count = 0; // number of failed assertions

    // reset cycles and the cycle right after them leave the report idle
    a_reset_idle: assert property (@(posedge clk)
        rst |=> (!chk_valid_i && (chk_fail_i == '0) && !chk_illegal_i))
        else begin
            fail_count++;
            $error("check outputs active during or just after reset");
        end

    a_latency: assert property (@(posedge clk) disable iff (rst)
        retire_valid_i |-> ##2 chk_valid_i)
        else begin
            fail_count++;
            $error("no check output two cycles after a retired record");
        end

    // no report without a record two cycles earlier
    a_no_spurious: assert property (@(posedge clk) disable iff (rst)
        chk_valid_i |-> $past(retire_valid_i, 2))
        else begin
            fail_count++;
            $error("check output without a retired record two cycles earlier");
        end

    a_flags_quiet: assert property (@(posedge clk) disable iff (rst)
        !chk_valid_i |-> ((chk_fail_i == '0) && !chk_illegal_i))
        else begin
            fail_count++;
            $error("failure flags set while no check output is valid");
        end

endmodule

bind rv_retire_monitor rv_retire_monitor_chk u_chk (
    .clk            (clk),
    .rst            (rst),
    .retire_valid_i (retire_valid_i),
    .chk_valid_i    (chk_valid_o),
    .chk_fail_i     (chk_fail_o),
    .chk_illegal_i  (chk_illegal_o)
);

`default_nettype wire

// ==== tb_scoreboard.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_scoreboard (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              push_i,
    input  logic [rv_monitor_pkg::FAIL_W-1:0] exp_fail_i,
    input  logic                              exp_illegal_i,
    input  logic                              chk_valid_i,
    input  logic [rv_monitor_pkg::FAIL_W-1:0] chk_fail_i,
    input  logic                              chk_illegal_i,
    input  logic                              end_i,
    output int                                value_errs_o,
    output int                                seq_errs_o,
    output int                                out_count_o
);

    logic [rv_monitor_pkg::FAIL_W:0] exp_q [$]; // {illegal, fail mask} per record
    logic [rv_monitor_pkg::FAIL_W:0] exp_rec;
    logic                            end_seen;

    always @(posedge clk) begin
        if (rst) begin
            exp_q.delete();
            value_errs_o = 0;
            seq_errs_o   = 0;
            out_count_o  = 0;
            end_seen     = 1'b0;
        end else begin
            // pop before push so a stray output cannot claim a fresh record
            if (chk_valid_i) begin
                if (exp_q.size() == 0) begin
                    $display("check output at %0t arrived with no record pending", $time);
                    seq_errs_o++;
                end else begin
                    exp_rec = exp_q.pop_front();
                    if (chk_fail_i != exp_rec[rv_monitor_pkg::FAIL_W-1:0]) begin
                        $display("ERROR %0t record %0d chk_fail_o expected %h actual %h",
                                 $time, out_count_o, exp_rec[rv_monitor_pkg::FAIL_W-1:0],
                                 chk_fail_i);
                        value_errs_o++;
                    end
                    if (chk_illegal_i != exp_rec[rv_monitor_pkg::FAIL_W]) begin
                        $display("ERROR %0t record %0d chk_illegal_o expected %b actual %b",
                                 $time, out_count_o, exp_rec[rv_monitor_pkg::FAIL_W],
                                 chk_illegal_i);
                        value_errs_o++;
                    end
                    out_count_o++;
                end
            end
            if (push_i)
                exp_q.push_back({exp_illegal_i, exp_fail_i});
            if (end_i && !end_seen) begin
                end_seen = 1'b1;
                if (exp_q.size() != 0) begin
                    $display("%0d records were never reported by the monitor", exp_q.size());
                    seq_errs_o++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_rv_retire_monitor.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk_o
);

    initial clk_o = 1'b0;
    always #2 clk_o = ~clk_o; // 4 ns period

endmodule

module tb_rv_retire_monitor;

    localparam int          MAX_RECS      = 64;
    localparam int          DRAIN_TIMEOUT = 200; // cycles allowed for the last reports
    localparam logic [31:0] END_MARK      = 32'hffffffff;
    localparam logic [31:0] SEED          = 32'h047a2bdb;

    logic                                  clk;
    logic                                  rst;
    logic                                  retire_valid;
    logic [rv_monitor_pkg::XLEN-1:0]       retire_pc;
    logic [rv_monitor_pkg::XLEN-1:0]       retire_inst;
    logic [rv_monitor_pkg::XLEN-1:0]       retire_rs1;
    logic [rv_monitor_pkg::XLEN-1:0]       retire_rs2;
    logic [rv_monitor_pkg::XLEN-1:0]       retire_wb_val;
    logic [rv_monitor_pkg::REG_ADDR_W-1:0] retire_wb_dst;
    logic                                  retire_wb_we;
    logic [rv_monitor_pkg::FAIL_W-1:0]     exp_fail;
    logic                                  exp_illegal;
    logic                                  end_run;
    logic                                  chk_valid;
    logic [rv_monitor_pkg::FAIL_W-1:0]     chk_fail;
    logic                                  chk_illegal;
    int                                    value_errs;
    int                                    seq_errs;
    int                                    out_count;
    logic [179:0]                          vec_mem [MAX_RECS];

    // each line holds inst pc rs1 rs2 wb_val dst(8) we(4) fail(4) illegal(4)
    task automatic apply_record(input logic [179:0] rec);
        retire_valid  <= 1'b1;
        retire_inst   <= rec[179:148];
        retire_pc     <= rec[147:116];
        retire_rs1    <= rec[115:84];
        retire_rs2    <= rec[83:52];
        retire_wb_val <= rec[51:20];
        retire_wb_dst <= rec[16:12];
        retire_wb_we  <= rec[8];
        exp_fail      <= rec[7:4];
        exp_illegal   <= rec[0];
    endtask

    task automatic drive_idle();
        retire_valid <= 1'b0; // payload simply holds
    endtask

    tb_clock_gen u_clk_gen (
        .clk_o (clk)
    );

    rv_retire_monitor dut (
        .clk             (clk),
        .rst             (rst),
        .retire_valid_i  (retire_valid),
        .retire_pc_i     (retire_pc),
        .retire_inst_i   (retire_inst),
        .retire_rs1_i    (retire_rs1),
        .retire_rs2_i    (retire_rs2),
        .retire_wb_val_i (retire_wb_val),
        .retire_wb_dst_i (retire_wb_dst),
        .retire_wb_we_i  (retire_wb_we),
        .chk_valid_o     (chk_valid),
        .chk_fail_o      (chk_fail),
        .chk_illegal_o   (chk_illegal)
    );

    tb_scoreboard u_scoreboard (
        .clk           (clk),
        .rst           (rst),
        .push_i        (retire_valid),
        .exp_fail_i    (exp_fail),
        .exp_illegal_i (exp_illegal),
        .chk_valid_i   (chk_valid),
        .chk_fail_i    (chk_fail),
        .chk_illegal_i (chk_illegal),
        .end_i         (end_run),
        .value_errs_o  (value_errs),
        .seq_errs_o    (seq_errs),
        .out_count_o   (out_count)
    );

    initial begin : main_seq
        int n_recs;
        int idle;
        int waited;
        int i;
        int timeout_errs;
        int assert_errs;
        int total_errs;

        rst           = 1'b1;
        retire_valid  = 1'b0;
        retire_pc     = '0;
        retire_inst   = '0;
        retire_rs1    = '0;
        retire_rs2    = '0;
        retire_wb_val = '0;
        retire_wb_dst = '0;
        retire_wb_we  = 1'b0;
        exp_fail      = '0;
        exp_illegal   = 1'b0;
        end_run       = 1'b0;
        timeout_errs  = 0;
        void'($urandom(SEED));
        $readmemh("retire_vectors.hex", vec_mem);

        n_recs = 0;
        while (n_recs < MAX_RECS && vec_mem[n_recs][179:148] != END_MARK) begin
            n_recs++;
        end

        repeat (3) @(posedge clk);
        rst <= 1'b0;

        for (i = 0; i < n_recs; i++) begin
            @(posedge clk);
            apply_record(vec_mem[i]);
            if ($urandom % 2 == 1) begin // otherwise the next record follows back to back
                idle = $urandom % 3 + 1;
                repeat (idle) begin
                    @(posedge clk);
                    drive_idle();
                end
            end
        end
        @(posedge clk);
        drive_idle();

        // scoreboard counters are settled by the falling edge
        waited = 0;
        while (out_count < n_recs && waited < DRAIN_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (out_count < n_recs) begin
            $display("timeout: only %0d of %0d check outputs arrived", out_count, n_recs);
            timeout_errs = 1;
        end

        end_run <= 1'b1;
        repeat (2) @(negedge clk);
        assert_errs = dut.u_chk.fail_count;
        total_errs  = value_errs + seq_errs + assert_errs + timeout_errs;
        $display("errors: %0d value, %0d sequence, %0d assertion, %0d timeout",
                 value_errs, seq_errs, assert_errs, timeout_errs);
        if (total_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== retire_vectors.hex ====
// columns: inst_pc_rs1_rs2_wbval_dst_we_fail_illegal, one retired record per line
// fail bits: 0 value, 1 dst, 2 we, 3 pc; a record with inst ffffffff ends the list
fff14093_00001000_12345678_00000000_edcba987_01_1_0_0 // xori x1,x2,-1 first record
80000297_00001004_00000000_00000000_80001004_05_1_0_0 // auipc x5,0x80000
0f024193_00001008_0000aaaa_00000000_0000aa5b_03_1_1_0 // xori x3,x4,0xf0 bad value
00001297_0000100c_00000000_00000000_0000200c_06_1_2_0 // auipc x5 wrong dst
008000ef_00001010_00000000_00000000_00001014_01_1_0_0 // jal x1,+8
00514013_00001018_00000003_00000000_00000006_00_1_4_0 // xori x0 writes
fff14093_0000101c_00000000_00000000_ffffffff_01_0_4_0 // xori x1 no write
ff9ff06f_00001020_00000000_00000000_00001024_00_0_0_0 // jal x0,-8
003100b3_00001024_00000000_00000000_00000000_01_1_8_0 // add at pc after jal wrong
0020c863_00001028_fffffffe_00000001_00000000_00_0_0_0 // blt -2<1 taken +16
0020c863_00001038_00000005_fffffffd_00000000_00_0_0_0 // blt 5<-3 not taken
0020c863_0000103c_00000001_00000002_00000000_00_0_0_0 // blt 1<2 taken
fff14093_00001040_00000000_00000000_ffffffff_01_1_8_0 // fell through taken blt
023100b3_00001044_00000000_00000000_00000000_01_0_0_1 // r-type funct7 0000001
0020c963_00001048_00000000_00000000_00000000_00_1_4_1 // blt offset bit 1 set, writes
000000f3_0000104c_00000000_00000000_00000000_00_0_0_1 // ecall with rd set
008000ef_00001050_00000000_00000000_00001054_01_1_0_0 // jal x1,+8
00001297_00001054_00000000_00000000_00002054_05_1_8_0 // skipped jal target
0f024193_00001058_0000ff00_00000000_0000fff0_03_1_0_0 // xori x3,x4,0xf0
00001297_00002000_00000000_00000000_00003001_05_1_9_0 // wrong pc and value
ffffffff_00000000_00000000_00000000_00000000_00_0_0_0

// ==== sim.f ====
rv_monitor_pkg.sv
rv_inst_decoder.sv
rv_golden_alu.sv
rv_flow_tracker.sv
rv_result_compare.sv
rv_retire_monitor.sv
rv_retire_monitor_chk.sv
tb_scoreboard.sv
tb_rv_retire_monitor.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rv_retire_monitor
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
